//--- hdl/dcache_cfg_pkg.sv
// dcache configuration package: word and address widths plus default cache geometry
`default_nettype none

package dcache_cfg_pkg;

	// ------------------------------
	// datapath widths
	// ------------------------------
	// one cache line holds exactly one word
	localparam int WORD_W = 32;
	// word address, so no byte offset bits
	localparam int ADDR_W = 16;

	// ------------------------------
	// default geometry, overridden from the top
	// ------------------------------
	localparam int DEF_NUM_SETS = 16;
	// 1 or 2 only, one replacement bit per set
	localparam int DEF_NUM_WAYS = 2;
	// outstanding memory requests allowed
	localparam int DEF_MEM_CREDITS = 2;

endpackage

`default_nettype wire

//--- hdl/dcache_msg_pkg.sv
// dcache message package: operation kinds on the core and memory channels
`default_nettype none

package dcache_msg_pkg;

	// ------------------------------
	// core side
	// ------------------------------
	// store also gets a response, data zero
	typedef enum logic {
		CPU_LOAD  = 1'b0,
		CPU_STORE = 1'b1
	} cpu_op_e;

	// ------------------------------
	// memory side
	// ------------------------------
	// fill read returns one word on the response channel
	// writeback write carries the victim word, no response
	typedef enum logic {
		MEM_FILL_RD = 1'b0,
		MEM_WB_WR   = 1'b1
	} mem_op_e;

endpackage

`default_nettype wire

//--- hdl/dcache_array_if.sv
// dcache array interface: lookup, store/fill update and victim readout between ctrl and array
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if #(
	parameter int NUM_SETS = dcache_cfg_pkg::DEF_NUM_SETS
);

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int TAG_W = dcache_cfg_pkg::ADDR_W - IDX_W;

	// lookup address, from the latched request
	logic [TAG_W-1:0]                  lookup_tag;
	logic [IDX_W-1:0]                  lookup_idx;
	// update strobes, take effect at next edge
	logic                              store_en;
	logic [dcache_cfg_pkg::WORD_W-1:0] store_data;
	logic                              fill_en;
	logic [dcache_cfg_pkg::WORD_W-1:0] fill_data;
	// combinational lookup result
	logic                              hit;
	logic [dcache_cfg_pkg::WORD_W-1:0] hit_data;
	// way named by the replacement bit of the indexed set
	logic                              victim_valid;
	logic                              victim_dirty;
	logic [TAG_W-1:0]                  victim_tag;
	logic [dcache_cfg_pkg::WORD_W-1:0] victim_data;

	modport array_mp (
		input  lookup_tag, lookup_idx, store_en, store_data, fill_en, fill_data,
		output hit, hit_data, victim_valid, victim_dirty, victim_tag, victim_data
	);

	modport ctrl_mp (
		output lookup_tag, lookup_idx, store_en, store_data, fill_en, fill_data,
		input  hit, hit_data, victim_valid, victim_dirty, victim_tag, victim_data
	);

endinterface

`default_nettype wire

//--- hdl/dcache_array.sv
// dcache array: set-associative tag, data, valid, dirty and replacement storage
`timescale 1ns/1ps
`default_nettype none

module dcache_array #(
	parameter int NUM_SETS = dcache_cfg_pkg::DEF_NUM_SETS,
	parameter int NUM_WAYS = dcache_cfg_pkg::DEF_NUM_WAYS
) (
	input  logic              clk,
	input  logic              rst,
	dcache_array_if.array_mp  arr
);

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int TAG_W = dcache_cfg_pkg::ADDR_W - IDX_W;
	localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

	// ------------------------------
	// storage
	// ------------------------------
	logic [dcache_cfg_pkg::WORD_W-1:0] data_q [NUM_WAYS][NUM_SETS];
	logic [TAG_W-1:0]                  tag_q  [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0]               valid_q [NUM_WAYS];
	logic [NUM_SETS-1:0]               dirty_q [NUM_WAYS];
	// one bit per set, names the next victim way
	logic [NUM_SETS-1:0]               repl_q;

	logic [NUM_WAYS-1:0] way_hit;
	logic [WAY_W-1:0]    hit_way;
	logic [WAY_W-1:0]    victim_way;
	logic [WAY_W-1:0]    used_way;
	logic                touch;

	// ------------------------------
	// lookup
	// ------------------------------
	// compare tag against every way of the set
	always_comb begin
		way_hit = '0;
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_q[w][arr.lookup_idx] &&
				(tag_q[w][arr.lookup_idx] == arr.lookup_tag);
			if (way_hit[w])
				hit_way = WAY_W'(w);
		end
	end

	assign arr.hit      = |way_hit;
	assign arr.hit_data = data_q[hit_way][arr.lookup_idx];

	// direct mapped: always way 0
	assign victim_way = (NUM_WAYS > 1) ? WAY_W'(repl_q[arr.lookup_idx]) : '0;

	assign arr.victim_valid = valid_q[victim_way][arr.lookup_idx];
	assign arr.victim_dirty = dirty_q[victim_way][arr.lookup_idx];
	assign arr.victim_tag   = tag_q[victim_way][arr.lookup_idx];
	assign arr.victim_data  = data_q[victim_way][arr.lookup_idx];

	// ------------------------------
	// replacement tracking
	// ------------------------------
	// fill uses the victim, otherwise a hit uses the hitting way
	always_comb begin
		used_way = hit_way;
		touch    = arr.hit;
		if (arr.fill_en) begin
			used_way = victim_way;
			touch    = 1'b1;
		end
	end

	// ------------------------------
	// state update
	// ------------------------------
	// control bits: valid, dirty, replacement
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			repl_q <= '0;
		end else begin
			if (arr.fill_en) begin
				valid_q[victim_way][arr.lookup_idx] <= 1'b1;
				// store miss merges into the fill, line born dirty
				dirty_q[victim_way][arr.lookup_idx] <= arr.store_en;
			end else if (arr.store_en && arr.hit) begin
				dirty_q[hit_way][arr.lookup_idx] <= 1'b1;
			end
			// point away from the way just used
			if (touch && (NUM_WAYS > 1))
				repl_q[arr.lookup_idx] <= ~used_way[0];
		end
	end

	// tag and data words
	always_ff @(posedge clk) begin
		if (arr.fill_en) begin
			tag_q[victim_way][arr.lookup_idx]  <= arr.lookup_tag;
			// store data wins over the filled word
			data_q[victim_way][arr.lookup_idx] <= arr.store_en ? arr.store_data : arr.fill_data;
		end else if (arr.store_en && arr.hit) begin
			data_q[hit_way][arr.lookup_idx] <= arr.store_data;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
// dcache controller: request sequencing, write-allocate miss handling, writeback and credits
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int NUM_SETS    = dcache_cfg_pkg::DEF_NUM_SETS,
	parameter int MEM_CREDITS = dcache_cfg_pkg::DEF_MEM_CREDITS
) (
	input  logic                              clk,
	input  logic                              rst,
	// core request
	input  logic                              cpu_req_valid_i,
	input  dcache_msg_pkg::cpu_op_e           cpu_req_op_i,
	input  logic [dcache_cfg_pkg::ADDR_W-1:0] cpu_req_addr_i,
	input  logic [dcache_cfg_pkg::WORD_W-1:0] cpu_req_data_i,
	output logic                              cpu_req_ready_o,
	// core response
	output logic                              cpu_rsp_valid_o,
	output logic [dcache_cfg_pkg::WORD_W-1:0] cpu_rsp_data_o,
	// memory request
	output logic                              mem_req_valid_o,
	output dcache_msg_pkg::mem_op_e           mem_req_op_o,
	output logic [dcache_cfg_pkg::ADDR_W-1:0] mem_req_addr_o,
	output logic [dcache_cfg_pkg::WORD_W-1:0] mem_req_data_o,
	// memory credit return and fill response
	input  logic                              mem_credit_i,
	input  logic                              mem_rsp_valid_i,
	input  logic [dcache_cfg_pkg::WORD_W-1:0] mem_rsp_data_i,
	dcache_array_if.ctrl_mp                   arr
);

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int CNT_W = $clog2(MEM_CREDITS + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_WB,
		S_FILL_REQ,
		S_FILL_WAIT,
		S_RESPOND
	} state_e;

	state_e state_q;
	state_e state_d;

	// latched request
	dcache_msg_pkg::cpu_op_e           req_op_q;
	logic [dcache_cfg_pkg::ADDR_W-1:0] req_addr_q;
	logic [dcache_cfg_pkg::WORD_W-1:0] req_data_q;

	logic [CNT_W-1:0] credit_q;
	logic             credit_ok;
	logic             accept;
	logic             is_store;

	// ------------------------------
	// core handshake
	// ------------------------------
	assign cpu_req_ready_o = (state_q == S_IDLE);
	assign accept          = cpu_req_valid_i && cpu_req_ready_o;
	assign is_store        = (req_op_q == dcache_msg_pkg::CPU_STORE);

	always_ff @(posedge clk) begin
		if (accept) begin
			req_op_q   <= cpu_req_op_i;
			req_addr_q <= cpu_req_addr_i;
			req_data_q <= cpu_req_data_i;
		end
	end

	// hit answers in lookup, miss answers in respond
	assign cpu_rsp_valid_o = ((state_q == S_LOOKUP) && arr.hit) || (state_q == S_RESPOND);
	// after the fill the line hits, so hit_data is the loaded word
	assign cpu_rsp_data_o  = (cpu_rsp_valid_o && !is_store) ? arr.hit_data : '0;

	// ------------------------------
	// array side
	// ------------------------------
	// tag is upper bits, index lower bits
	assign arr.lookup_tag = req_addr_q[dcache_cfg_pkg::ADDR_W-1:IDX_W];
	assign arr.lookup_idx = req_addr_q[IDX_W-1:0];
	assign arr.store_data = req_data_q;
	assign arr.fill_data  = mem_rsp_data_i;
	assign arr.fill_en    = (state_q == S_FILL_WAIT) && mem_rsp_valid_i;
	// store hit, or store merged into its own fill
	assign arr.store_en   = is_store && (((state_q == S_LOOKUP) && arr.hit) || arr.fill_en);

	// ------------------------------
	// memory request and credits
	// ------------------------------
	assign credit_ok       = (credit_q != '0);
	assign mem_req_valid_o = credit_ok && ((state_q == S_WB) || (state_q == S_FILL_REQ));
	assign mem_req_op_o    = (state_q == S_WB) ? dcache_msg_pkg::MEM_WB_WR
		: dcache_msg_pkg::MEM_FILL_RD;
	// victim address rebuilt from its tag and the set index
	assign mem_req_addr_o  = (state_q == S_WB) ? {arr.victim_tag, arr.lookup_idx} : req_addr_q;
	assign mem_req_data_o  = (state_q == S_WB) ? arr.victim_data : '0;

	// one down per request, one up per returned credit
	always_ff @(posedge clk) begin
		if (rst)
			credit_q <= CNT_W'(MEM_CREDITS);
		else
			credit_q <= credit_q - CNT_W'(mem_req_valid_o) + CNT_W'(mem_credit_i);
	end

	// ------------------------------
	// FSM
	// ------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (accept)
					state_d = S_LOOKUP;
			end
			S_LOOKUP: begin
				if (arr.hit)
					state_d = S_IDLE;
				else if (arr.victim_valid && arr.victim_dirty)
					state_d = S_WB;
				else
					state_d = S_FILL_REQ;
			end
			// hold until a credit frees up
			S_WB: begin
				if (credit_ok)
					state_d = S_FILL_REQ;
			end
			S_FILL_REQ: begin
				if (credit_ok)
					state_d = S_FILL_WAIT;
			end
			S_FILL_WAIT: begin
				if (mem_rsp_valid_i)
					state_d = S_RESPOND;
			end
			S_RESPOND: state_d = S_IDLE;
			default:   state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= S_IDLE;
		else
			state_q <= state_d;
	end

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
// dcache top: controller and array joined by the array interface, plain core and memory ports
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int NUM_SETS    = dcache_cfg_pkg::DEF_NUM_SETS,
	parameter int NUM_WAYS    = dcache_cfg_pkg::DEF_NUM_WAYS,
	parameter int MEM_CREDITS = dcache_cfg_pkg::DEF_MEM_CREDITS
) (
	input  logic                              clk,
	input  logic                              rst,
	// ------------------------------
	// core
	// ------------------------------
	input  logic                              cpu_req_valid_i,
	output logic                              cpu_req_ready_o,
	input  dcache_msg_pkg::cpu_op_e           cpu_req_op_i,
	input  logic [dcache_cfg_pkg::ADDR_W-1:0] cpu_req_addr_i,
	input  logic [dcache_cfg_pkg::WORD_W-1:0] cpu_req_data_i,
	output logic                              cpu_rsp_valid_o,
	output logic [dcache_cfg_pkg::WORD_W-1:0] cpu_rsp_data_o,
	// ------------------------------
	// memory
	// ------------------------------
	output logic                              mem_req_valid_o,
	output dcache_msg_pkg::mem_op_e           mem_req_op_o,
	output logic [dcache_cfg_pkg::ADDR_W-1:0] mem_req_addr_o,
	output logic [dcache_cfg_pkg::WORD_W-1:0] mem_req_data_o,
	input  logic                              mem_credit_i,
	input  logic                              mem_rsp_valid_i,
	input  logic [dcache_cfg_pkg::WORD_W-1:0] mem_rsp_data_i
);

	// ctrl to array link
	dcache_array_if #(.NUM_SETS(NUM_SETS)) arr_if ();

	dcache_ctrl #(
		.NUM_SETS    (NUM_SETS),
		.MEM_CREDITS (MEM_CREDITS)
	) u_ctrl (
		.clk             (clk),
		.rst             (rst),
		.cpu_req_valid_i (cpu_req_valid_i),
		.cpu_req_op_i    (cpu_req_op_i),
		.cpu_req_addr_i  (cpu_req_addr_i),
		.cpu_req_data_i  (cpu_req_data_i),
		.cpu_req_ready_o (cpu_req_ready_o),
		.cpu_rsp_valid_o (cpu_rsp_valid_o),
		.cpu_rsp_data_o  (cpu_rsp_data_o),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_op_o    (mem_req_op_o),
		.mem_req_addr_o  (mem_req_addr_o),
		.mem_req_data_o  (mem_req_data_o),
		.mem_credit_i    (mem_credit_i),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.mem_rsp_data_i  (mem_rsp_data_i),
		.arr             (arr_if.ctrl_mp)
	);

	dcache_array #(
		.NUM_SETS (NUM_SETS),
		.NUM_WAYS (NUM_WAYS)
	) u_array (
		.clk (clk),
		.rst (rst),
		.arr (arr_if.array_mp)
	);

endmodule

`default_nettype wire

//--- testbench/dcache_assert.sv
// dcache controller assertions: credit use, ready while busy and fill response timing
`timescale 1ns/1ps
`default_nettype none

module dcache_assert #(
	parameter int MEM_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic cpu_req_valid_i,
	input logic cpu_req_ready_o,
	input logic cpu_rsp_valid_o,
	input logic mem_req_valid_o,
	input logic mem_credit_i,
	input logic mem_rsp_valid_i,
	input logic fill_wait
);

	// failures seen, read by the testbench at the end
	int fail_count = 0;

	// own count of free credits, seen from the ports
	int   credits;
	// from accepting edge until the response cycle
	logic in_flight;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits   <= MEM_CREDITS;
			in_flight <= 1'b0;
		end else begin
			credits <= credits - int'(mem_req_valid_o) + int'(mem_credit_i);
			if (cpu_req_valid_i && cpu_req_ready_o)
				in_flight <= 1'b1;
			else if (cpu_rsp_valid_o)
				in_flight <= 1'b0;
		end
	end

	// ------------------------------
	// memory channel
	// ------------------------------
	// no request goes out without a credit
	a_credit: assert property (@(posedge clk) disable iff (rst)
		(credits == 0) |-> !mem_req_valid_o)
		else begin
			$error("memory request raised with zero credits");
			fail_count++;
		end

	// fill data only while the FSM waits for it
	a_fill: assert property (@(posedge clk) disable iff (rst)
		mem_rsp_valid_i |-> fill_wait)
		else begin
			$error("fill response outside the fill wait state");
			fail_count++;
		end

	// ------------------------------
	// core channel
	// ------------------------------
	a_busy: assert property (@(posedge clk) disable iff (rst)
		in_flight |-> !cpu_req_ready_o)
		else begin
			$error("core ready high with a request in flight");
			fail_count++;
		end

endmodule

bind dcache_ctrl dcache_assert #(
	.MEM_CREDITS (MEM_CREDITS)
) u_assert (
	.clk             (clk),
	.rst             (rst),
	.cpu_req_valid_i (cpu_req_valid_i),
	.cpu_req_ready_o (cpu_req_ready_o),
	.cpu_rsp_valid_o (cpu_rsp_valid_o),
	.mem_req_valid_o (mem_req_valid_o),
	.mem_credit_i    (mem_credit_i),
	.mem_rsp_valid_i (mem_rsp_valid_i),
	.fill_wait       (state_q == S_FILL_WAIT)
);

`default_nettype wire

//--- testbench/dcache_checker.sv
// dcache checker: watches core and memory ports, keeps expected memory and a cache shadow
`timescale 1ns/1ps
`default_nettype none

module dcache_checker #(
	parameter int          NUM_SETS    = 16,
	parameter int          NUM_WAYS    = 2,
	parameter int          MEM_CREDITS = 2,
	parameter int          NUM_REQS    = 400,
	parameter logic [31:0] INIT_XOR    = 32'h0
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              cpu_req_valid_i,
	input  logic                              cpu_req_ready_o,
	input  dcache_msg_pkg::cpu_op_e           cpu_req_op_i,
	input  logic [dcache_cfg_pkg::ADDR_W-1:0] cpu_req_addr_i,
	input  logic [dcache_cfg_pkg::WORD_W-1:0] cpu_req_data_i,
	input  logic                              cpu_rsp_valid_o,
	input  logic [dcache_cfg_pkg::WORD_W-1:0] cpu_rsp_data_o,
	input  logic                              mem_req_valid_o,
	input  dcache_msg_pkg::mem_op_e           mem_req_op_o,
	input  logic [dcache_cfg_pkg::ADDR_W-1:0] mem_req_addr_o,
	input  logic [dcache_cfg_pkg::WORD_W-1:0] mem_req_data_o,
	input  logic                              mem_credit_i,
	input  logic                              mem_rsp_valid_i,
	input  logic                              end_i,
	output int                                err_count_o,
	output int                                done_count_o
);

	localparam int MEM_WORDS = 1 << dcache_cfg_pkg::ADDR_W;

	// core view of memory, last stored value per word
	logic [31:0] exp_mem [0:MEM_WORDS-1];
	// shadow of tags and state, same replacement rule as the cache
	logic        sh_valid [NUM_WAYS][NUM_SETS];
	logic        sh_dirty [NUM_WAYS][NUM_SETS];
	int          sh_tag   [NUM_WAYS][NUM_SETS];
	int          sh_repl  [NUM_SETS];

	int          err_count = 0;
	int          done_count = 0;
	int          cyc = 0;
	int          outstanding = 0;
	int          acc_cyc;
	int          rsp_in_cyc;
	int          test_err_start;
	int          cur_idx;
	int          cur_tag;
	int          hit_way;
	int          vic_way;
	int          wb_addr;
	logic        pending = 1'b0;
	logic        exp_hit;
	logic        exp_wb;
	logic        seen_wb;
	logic        seen_fill;
	logic        repeat_load;
	logic        have_prev = 1'b0;
	logic        rst_q = 1'b0;
	logic        end_done = 1'b0;
	logic [15:0] cur_addr;
	logic [15:0] prev_addr;
	logic [31:0] cur_data;
	logic [31:0] exp_rd;
	string       cur_name = "idle";
	dcache_msg_pkg::cpu_op_e cur_op;

	assign err_count_o  = err_count;
	assign done_count_o = done_count;

	// initial word is the address xor a constant
	initial begin
		for (int a = 0; a < MEM_WORDS; a++)
			exp_mem[a] = 32'(a) ^ INIT_XOR;
	end

	// ------------------------------
	// reporting
	// ------------------------------
	task automatic report_value(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("ERROR %s %s: expected 0x%08h, actual 0x%08h", cur_name, what, exp_v, act_v);
		err_count++;
	endtask

	task automatic report_fault(input string msg);
		$display("%s: %s", cur_name, msg);
		err_count++;
	endtask

	// ------------------------------
	// per request
	// ------------------------------
	// latch the request and predict hit or miss from the shadow
	task automatic start_request();
		cur_op         = cpu_req_op_i;
		cur_addr       = cpu_req_addr_i;
		cur_data       = cpu_req_data_i;
		acc_cyc        = cyc;
		pending        = 1'b1;
		seen_wb        = 1'b0;
		seen_fill      = 1'b0;
		test_err_start = err_count;
		cur_idx        = int'(cur_addr) % NUM_SETS;
		cur_tag        = int'(cur_addr) / NUM_SETS;
		cur_name       = $sformatf("req%0d_%s_%04h", done_count,
			(cur_op == dcache_msg_pkg::CPU_STORE) ? "store" : "load", cur_addr);
		repeat_load = have_prev && (cur_addr == prev_addr) &&
			(cur_op == dcache_msg_pkg::CPU_LOAD);
		exp_hit = 1'b0;
		hit_way = 0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sh_valid[w][cur_idx] && (sh_tag[w][cur_idx] == cur_tag)) begin
				exp_hit = 1'b1;
				hit_way = w;
			end
		end
		vic_way = (NUM_WAYS > 1) ? sh_repl[cur_idx] : 0;
		exp_wb  = !exp_hit && sh_valid[vic_way][cur_idx] && sh_dirty[vic_way][cur_idx];
		wb_addr = sh_tag[vic_way][cur_idx] * NUM_SETS + cur_idx;
	endtask

	// writeback first when the victim is dirty, then exactly one fill
	task automatic check_mem_request();
		if (!pending) begin
			report_fault("memory request while no core request is in flight");
		end else if (exp_hit) begin
			report_fault("memory request issued for a request that should hit");
		end else if (mem_req_op_o == dcache_msg_pkg::MEM_WB_WR) begin
			if (!exp_wb || seen_wb || seen_fill) begin
				report_fault("writeback issued although the victim was not dirty");
			end else begin
				seen_wb = 1'b1;
				if (mem_req_addr_o != 16'(wb_addr))
					report_value("writeback address", 32'(wb_addr), 32'(mem_req_addr_o));
				if (mem_req_data_o != exp_mem[wb_addr])
					report_value("writeback data", exp_mem[wb_addr], mem_req_data_o);
			end
		end else begin
			if (exp_wb && !seen_wb)
				report_fault("fill issued before the dirty victim was written back");
			if (seen_fill)
				report_fault("second fill issued for one request");
			seen_fill = 1'b1;
			if (mem_req_addr_o != cur_addr)
				report_value("fill address", 32'(cur_addr), 32'(mem_req_addr_o));
		end
	endtask

	task automatic finish_request();
		if (!pending) begin
			report_fault("core response with no request in flight");
		end else begin
			if (exp_hit && (cyc - acc_cyc != 1))
				report_value("hit latency", 32'd1, 32'(cyc - acc_cyc));
			if (repeat_load && (cyc - acc_cyc != 1))
				report_fault("repeated load of the same address did not hit");
			if (!exp_hit && !seen_fill)
				report_fault("miss answered without a fill request");
			if (!exp_hit && exp_wb && !seen_wb)
				report_fault("miss answered without writing back the dirty victim");
			if (!exp_hit && seen_fill && (cyc - rsp_in_cyc != 1))
				report_fault("miss response not one cycle after the fill data");
			exp_rd = (cur_op == dcache_msg_pkg::CPU_STORE) ? 32'h0 : exp_mem[cur_addr];
			if (cpu_rsp_data_o != exp_rd)
				report_value("response data", exp_rd, cpu_rsp_data_o);
			if (cur_op == dcache_msg_pkg::CPU_STORE)
				exp_mem[cur_addr] = cur_data;
			// shadow follows the cache, replacement points away from the used way
			if (exp_hit) begin
				if (cur_op == dcache_msg_pkg::CPU_STORE)
					sh_dirty[hit_way][cur_idx] = 1'b1;
				sh_repl[cur_idx] = (hit_way == 0) ? 1 : 0;
			end else begin
				sh_valid[vic_way][cur_idx] = 1'b1;
				sh_tag[vic_way][cur_idx]   = cur_tag;
				sh_dirty[vic_way][cur_idx] = (cur_op == dcache_msg_pkg::CPU_STORE);
				sh_repl[cur_idx]           = (vic_way == 0) ? 1 : 0;
			end
			if (NUM_WAYS == 1)
				sh_repl[cur_idx] = 0;
			$display("%s %s %s", cur_name, exp_hit ? "hit" : "miss",
				(err_count == test_err_start) ? "pass" : "FAIL");
			done_count++;
			prev_addr = cur_addr;
			have_prev = 1'b1;
			pending   = 1'b0;
		end
	endtask

	// ------------------------------
	// sampling at each rising edge
	// ------------------------------
	always @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					sh_valid[w][s] = 1'b0;
					sh_dirty[w][s] = 1'b0;
				end
			end
			for (int s = 0; s < NUM_SETS; s++)
				sh_repl[s] = 0;
			pending     = 1'b0;
			outstanding = 0;
		end else begin
			cyc++;
			// first edge out of reset
			if (rst_q) begin
				cur_name       = "reset_state";
				test_err_start = err_count;
				if (!cpu_req_ready_o)
					report_fault("core ready low after reset");
				if (cpu_rsp_valid_o)
					report_fault("core response valid high after reset");
				if (mem_req_valid_o)
					report_fault("memory request valid high after reset");
				$display("%s %s", cur_name, (err_count == test_err_start) ? "pass" : "FAIL");
			end
			if (mem_credit_i) begin
				if (outstanding == 0)
					report_fault("credit returned with no memory request outstanding");
				else
					outstanding--;
			end
			if (mem_req_valid_o) begin
				outstanding++;
				if (outstanding > MEM_CREDITS)
					report_fault("more memory requests outstanding than credits");
				check_mem_request();
			end
			if (mem_rsp_valid_i)
				rsp_in_cyc = cyc;
			if (cpu_rsp_valid_o)
				finish_request();
			if (cpu_req_valid_i && cpu_req_ready_o)
				start_request();
			if (end_i && !end_done) begin
				end_done = 1'b1;
				cur_name = "end_of_run";
				if (pending)
					report_fault("a core request is still in flight");
				if (done_count != NUM_REQS)
					report_fault($sformatf("only %0d of %0d requests answered",
						done_count, NUM_REQS));
				if (outstanding != 0)
					report_fault($sformatf("%0d memory credits never returned", outstanding));
			end
		end
		rst_q = rst;
	end

endmodule

`default_nettype wire

//--- testbench/dcache_tb.sv
// dcache testbench: random core traffic, memory model with credit return, timeout and report
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	localparam int          NUM_SETS       = 16;
	localparam int          NUM_WAYS       = 2;
	localparam int          MEM_CREDITS    = 2;
	localparam int          NUM_REQS       = 400;
	localparam int          RST_CYCLES     = 16;
	localparam int          TIMEOUT_CYCLES = NUM_REQS * 40 + RST_CYCLES;
	localparam logic [31:0] SEED           = 32'h6d39cd54;
	localparam logic [31:0] INIT_XOR       = 32'h3c5a_96e1;
	localparam int          MEM_WORDS      = 1 << dcache_cfg_pkg::ADDR_W;

	logic                              clk;
	logic                              rst;
	logic                              cpu_req_valid_i;
	logic                              cpu_req_ready_o;
	dcache_msg_pkg::cpu_op_e           cpu_req_op_i;
	logic [dcache_cfg_pkg::ADDR_W-1:0] cpu_req_addr_i;
	logic [dcache_cfg_pkg::WORD_W-1:0] cpu_req_data_i;
	logic                              cpu_rsp_valid_o;
	logic [dcache_cfg_pkg::WORD_W-1:0] cpu_rsp_data_o;
	logic                              mem_req_valid_o;
	dcache_msg_pkg::mem_op_e           mem_req_op_o;
	logic [dcache_cfg_pkg::ADDR_W-1:0] mem_req_addr_o;
	logic [dcache_cfg_pkg::WORD_W-1:0] mem_req_data_o;
	logic                              mem_credit_i;
	logic                              mem_rsp_valid_i;
	logic [dcache_cfg_pkg::WORD_W-1:0] mem_rsp_data_i;

	logic [31:0] lcg_state;
	// memory image behind the cache
	logic [31:0] mem_img [0:MEM_WORDS-1];
	int          credit_due [$];
	int          mem_cyc = 0;
	int          fill_due;
	logic        fill_busy = 1'b0;
	logic [15:0] fill_addr;
	int          cycles = 0;
	logic        end_run;
	int          err_count;
	int          done_count;

	dcache_top #(
		.NUM_SETS    (NUM_SETS),
		.NUM_WAYS    (NUM_WAYS),
		.MEM_CREDITS (MEM_CREDITS)
	) u_dut (
		.clk             (clk),
		.rst             (rst),
		.cpu_req_valid_i (cpu_req_valid_i),
		.cpu_req_ready_o (cpu_req_ready_o),
		.cpu_req_op_i    (cpu_req_op_i),
		.cpu_req_addr_i  (cpu_req_addr_i),
		.cpu_req_data_i  (cpu_req_data_i),
		.cpu_rsp_valid_o (cpu_rsp_valid_o),
		.cpu_rsp_data_o  (cpu_rsp_data_o),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_op_o    (mem_req_op_o),
		.mem_req_addr_o  (mem_req_addr_o),
		.mem_req_data_o  (mem_req_data_o),
		.mem_credit_i    (mem_credit_i),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.mem_rsp_data_i  (mem_rsp_data_i)
	);

	dcache_checker #(
		.NUM_SETS    (NUM_SETS),
		.NUM_WAYS    (NUM_WAYS),
		.MEM_CREDITS (MEM_CREDITS),
		.NUM_REQS    (NUM_REQS),
		.INIT_XOR    (INIT_XOR)
	) u_chk (
		.clk             (clk),
		.rst             (rst),
		.cpu_req_valid_i (cpu_req_valid_i),
		.cpu_req_ready_o (cpu_req_ready_o),
		.cpu_req_op_i    (cpu_req_op_i),
		.cpu_req_addr_i  (cpu_req_addr_i),
		.cpu_req_data_i  (cpu_req_data_i),
		.cpu_rsp_valid_o (cpu_rsp_valid_o),
		.cpu_rsp_data_o  (cpu_rsp_data_o),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_op_o    (mem_req_op_o),
		.mem_req_addr_o  (mem_req_addr_o),
		.mem_req_data_o  (mem_req_data_o),
		.mem_credit_i    (mem_credit_i),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.end_i           (end_run),
		.err_count_o     (err_count),
		.done_count_o    (done_count)
	);

	// ------------------------------
	// clock, random numbers
	// ------------------------------
	always #20 clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ------------------------------
	// memory model
	// ------------------------------
	// requests sampled at the edge, credit and fill driven 2 ns later
	always @(posedge clk) begin
		logic        give_credit;
		logic        give_fill;
		logic [31:0] fill_word;
		give_credit = 1'b0;
		give_fill   = 1'b0;
		fill_word   = '0;
		if (rst) begin
			credit_due.delete();
			fill_busy = 1'b0;
			mem_cyc   = 0;
		end else begin
			mem_cyc++;
			if (mem_req_valid_o) begin
				// one credit back 1 to 6 cycles later
				credit_due.push_back(mem_cyc + 1 + int'((next_rand() >> 8) % 6));
				if (mem_req_op_o == dcache_msg_pkg::MEM_WB_WR) begin
					mem_img[mem_req_addr_o] = mem_req_data_o;
				end else begin
					fill_due  = mem_cyc + 2 + int'((next_rand() >> 8) % 7);
					fill_addr = mem_req_addr_o;
					fill_busy = 1'b1;
				end
			end
			// at most one credit per cycle, late ones wait
			for (int i = 0; i < credit_due.size(); i++) begin
				if (!give_credit && (credit_due[i] <= mem_cyc)) begin
					credit_due.delete(i);
					give_credit = 1'b1;
				end
			end
			if (fill_busy && (fill_due <= mem_cyc)) begin
				give_fill = 1'b1;
				fill_busy = 1'b0;
				fill_word = mem_img[fill_addr];
			end
		end
		#2;
		mem_credit_i    = give_credit;
		mem_rsp_valid_i = give_fill;
		mem_rsp_data_i  = fill_word;
	end

	// ------------------------------
	// timeout
	// ------------------------------
	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d requests answered",
				cycles, done_count, NUM_REQS);
			$display("Something failed");
			$finish;
		end
	end

	// ------------------------------
	// core driver
	// ------------------------------
	// called 2 ns after an edge, returns 2 ns after the response edge
	task automatic issue_request(input dcache_msg_pkg::cpu_op_e op, input logic [15:0] addr,
		input logic [31:0] data);
		cpu_req_valid_i = 1'b1;
		cpu_req_op_i    = op;
		cpu_req_addr_i  = addr;
		cpu_req_data_i  = data;
		do
			@(posedge clk);
		while (!cpu_req_ready_o);
		#2;
		cpu_req_valid_i = 1'b0;
		do
			@(posedge clk);
		while (!cpu_rsp_valid_o);
		#2;
	endtask

	initial begin
		dcache_msg_pkg::cpu_op_e op;
		logic [15:0]             addr;
		logic [15:0]             prev_addr;
		logic [31:0]             r;
		logic                    have_prev;
		int                      set_k;
		int                      tag_k;
		clk             = 1'b0;
		rst             = 1'b1;
		end_run         = 1'b0;
		cpu_req_valid_i = 1'b0;
		cpu_req_op_i    = dcache_msg_pkg::CPU_LOAD;
		cpu_req_addr_i  = '0;
		cpu_req_data_i  = '0;
		mem_credit_i    = 1'b0;
		mem_rsp_valid_i = 1'b0;
		mem_rsp_data_i  = '0;
		lcg_state       = SEED;
		have_prev       = 1'b0;
		prev_addr       = '0;
		for (int a = 0; a < MEM_WORDS; a++)
			mem_img[a] = 32'(a) ^ INIT_XOR;
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int n = 0; n < NUM_REQS; n++) begin
			r = next_rand();
			if (have_prev && (r[3:0] < 4'd4)) begin
				// repeat load, must hit
				op   = dcache_msg_pkg::CPU_LOAD;
				addr = prev_addr;
			end else begin
				op    = r[4] ? dcache_msg_pkg::CPU_STORE : dcache_msg_pkg::CPU_LOAD;
				// 6 tags in each of 4 sets, 24 words
				set_k = int'((r >> 8) % 4);
				tag_k = int'((r >> 12) % 6);
				addr  = 16'((tag_k * 5 + 1) * NUM_SETS + (set_k * 3 + 2));
			end
			issue_request(op, addr, next_rand());
			prev_addr = addr;
			have_prev = 1'b1;
		end
		// let the last credits come home
		repeat (12) @(posedge clk);
		#2;
		end_run = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		$display("requests %0d, answered %0d, check errors %0d, assertion failures %0d",
			NUM_REQS, done_count, err_count, u_dut.u_ctrl.u_assert.fail_count);
		if ((err_count == 0) && (u_dut.u_ctrl.u_assert.fail_count == 0))
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- dcache.f
hdl/dcache_cfg_pkg.sv
hdl/dcache_msg_pkg.sv
hdl/dcache_array_if.sv
hdl/dcache_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_assert.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv
